/* include/spi_reg_config.svh */
`ifndef SPI_REG_CONFIG_SVH
`define SPI_REG_CONFIG_SVH

// Register bank geometry.
`define REG_COUNT 16                // Registers in the bank.
`define REG_ADDR_W 4                // Bits to index REG_COUNT entries.

// Oversampling front end.
`define SYNC_STAGES 3               // Flops per pin synchronizer.

// Fixed register map.
`define GPIO_IN_ADDR 1              // Read-only input pin register.

`endif

/* design/spi_pkg.sv */
`default_nettype none

package spi_pkg;

	// One clk cycle of pin activity seen after synchronization.
	typedef struct packed {
		logic mosi;                 // Synchronized MOSI level.
		logic sck_rise;             // SCK went high this cycle.
		logic cs_fall;              // Frame start.
		logic cs_rise;              // Frame end.
	} spi_events_t;

	typedef struct packed {
		logic [7:0] data;           // Assembled byte, MSB first on the wire.
		logic       valid;          // One-cycle strobe per byte.
	} rx_byte_t;

	typedef struct packed {
		logic [7:0] data;           // Next byte to shift onto MISO.
		logic       load;           // Replace the shift register now.
	} tx_byte_t;

endpackage

`default_nettype wire

/* design/reg_pkg.sv */
`default_nettype none
`include "spi_reg_config.svh"

package reg_pkg;

	// ==============================
	// Command byte, byte 0 of every frame
	// ==============================

	typedef struct packed {
		logic       read;           // Bit 7, set for a read frame.
		logic [6:0] addr;           // Start address, only low bits used.
	} cmd_fields_t;

	// Same word as the transceiver sees it and as the decoder reads it.
	typedef union packed {
		logic [7:0]  raw;           // Plain received data.
		cmd_fields_t fields;        // Decoded command view.
	} cmd_byte_u;

	// ==============================
	// Register bank write port
	// ==============================

	typedef struct packed {
		logic                   write;  // One-cycle write strobe.
		logic [`REG_ADDR_W-1:0] addr;   // Target register.
		logic [7:0]             wdata;  // Byte to store.
	} reg_access_t;

endpackage

`default_nettype wire

/* design/spi_input_sync.sv */
`timescale 1ns/10ps
`default_nettype none
`include "spi_reg_config.svh"

module spi_input_sync (
	input wire clk,
	input wire reset,
	input wire spi_sck,
	input wire spi_mosi,
	input wire spi_cs_n,
	output spi_pkg::spi_events_t events
);

	// ==============================
	// Pin synchronizers
	// ==============================

	logic [`SYNC_STAGES-1:0] sck_sync;      // Oldest sample at the top bit.
	logic [`SYNC_STAGES-1:0] mosi_sync;
	logic [`SYNC_STAGES-1:0] cs_n_sync;
	logic sck_s;                            // Chain outputs.
	logic mosi_s;
	logic cs_n_s;
	logic sck_hist;                         // Previous synchronized levels.
	logic cs_n_hist;

	assign sck_s  = sck_sync[`SYNC_STAGES-1];
	assign mosi_s = mosi_sync[`SYNC_STAGES-1];
	assign cs_n_s = cs_n_sync[`SYNC_STAGES-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			sck_sync  <= '0;
			mosi_sync <= '0;
			cs_n_sync <= '1;                // Bus idle, device deselected.
			sck_hist  <= 1'b0;
			cs_n_hist <= 1'b1;
			events    <= '0;
		end else begin
			sck_sync  <= {sck_sync[`SYNC_STAGES-2:0], spi_sck};
			mosi_sync <= {mosi_sync[`SYNC_STAGES-2:0], spi_mosi};
			cs_n_sync <= {cs_n_sync[`SYNC_STAGES-2:0], spi_cs_n};
			sck_hist  <= sck_s;
			cs_n_hist <= cs_n_s;
			// Edge detect, registered so all fields line up.
			events.mosi     <= mosi_s;
			events.sck_rise <= sck_s & ~sck_hist;
			events.cs_fall  <= cs_n_hist & ~cs_n_s;
			events.cs_rise  <= ~cs_n_hist & cs_n_s;
		end
	end

endmodule

`default_nettype wire

/* design/spi_device_transceiver.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_device_transceiver (
	input wire clk,
	input wire reset,
	input wire spi_pkg::spi_events_t events,
	input wire spi_pkg::tx_byte_t tx,
	output spi_pkg::rx_byte_t rx,
	output logic spi_miso
);

	// ==============================
	// Shift engine
	// ==============================

	logic [2:0] bit_count;          // Bits of the current byte seen so far.
	logic [7:0] rx_shift;           // Receive shift register.
	logic [7:0] tx_shift;           // Transmit shift register, MSB on MISO.
	logic [7:0] rx_data;            // Last complete byte.
	logic       rx_valid;           // Byte strobe.
	logic       last_bit;           // Eighth bit arriving this cycle.

	assign last_bit = events.sck_rise && (bit_count == 3'd7);
	assign spi_miso = tx_shift[7];  // MSB first.

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_count <= 3'd0;
			tx_shift  <= 8'h00;     // Keeps MISO low out of reset.
			rx_valid  <= 1'b0;
		end else begin
			rx_valid <= last_bit;   // Pulse one cycle after the last SCK rise.

			if (events.cs_fall) begin
				bit_count <= 3'd0;  // Realign to the byte boundary.
				tx_shift  <= tx.data;
			end else if (events.sck_rise) begin
				bit_count <= bit_count + 3'd1;
				tx_shift  <= {tx_shift[6:0], 1'b0};
			end

			// A fresh byte from the decoder overrides the shift.
			if (tx.load)
				tx_shift <= tx.data;
		end
	end

	// Receive data path.
	always_ff @(posedge clk) begin
		if (events.sck_rise)
			rx_shift <= {rx_shift[6:0], events.mosi};
		if (last_bit)
			rx_data <= {rx_shift[6:0], events.mosi};
	end

	assign rx.data  = rx_data;
	assign rx.valid = rx_valid;

	// Bytes are eight SCK rises apart, so strobes never touch.
	rx_valid_single: assert property (
		@(posedge clk) disable iff (reset)
		rx_valid |=> !rx_valid
	);

endmodule

`default_nettype wire

/* design/spi_frame_decoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "spi_reg_config.svh"

module spi_frame_decoder (
	input wire clk,
	input wire reset,
	input wire spi_pkg::spi_events_t events,
	input wire spi_pkg::rx_byte_t rx,
	output spi_pkg::tx_byte_t tx,
	output reg_pkg::reg_access_t access,
	output logic [`REG_ADDR_W-1:0] rd_addr,
	input wire [7:0] rd_data
);

	// ==============================
	// Frame state
	// ==============================

	reg_pkg::cmd_byte_u cmd;                // Received byte as a command.
	logic expect_cmd;                       // Next byte is byte 0.
	logic frame_is_read;                    // Latched from the command.
	logic [`REG_ADDR_W-1:0] addr;           // Current register pointer.
	logic [`REG_ADDR_W-1:0] addr_next;      // Pointer after wrap.
	logic act_pending;                      // Access due this cycle.
	logic [7:0] wdata;                      // Held write byte.
	logic [7:0] frame_count;                // Completed frames, mod 256.

	assign cmd.raw = rx.data;

	// Wrap at the end of the bank.
	assign addr_next = (addr == `REG_ADDR_W'(`REG_COUNT - 1)) ? '0 : addr + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			expect_cmd    <= 1'b1;
			frame_is_read <= 1'b0;
			addr          <= '0;
			act_pending   <= 1'b0;
			frame_count   <= 8'h00;
		end else begin
			act_pending <= 1'b0;

			// Access done, step to the next register.
			if (act_pending)
				addr <= addr_next;

			if (rx.valid) begin
				if (expect_cmd) begin
					expect_cmd    <= 1'b0;
					frame_is_read <= cmd.fields.read;
					addr          <= cmd.fields.addr[`REG_ADDR_W-1:0];  // Mod REG_COUNT.
					act_pending   <= cmd.fields.read;    // Preload first read slot.
				end else begin
					act_pending   <= 1'b1;               // Write it or fetch the next.
				end
			end

			if (events.cs_fall) begin
				expect_cmd    <= 1'b1;      // New frame, command comes first.
				frame_is_read <= 1'b0;
				act_pending   <= 1'b0;
			end

			if (events.cs_rise)
				frame_count <= frame_count + 8'd1;
		end
	end

	// Payload capture.
	always_ff @(posedge clk) begin
		if (rx.valid)
			wdata <= rx.data;
	end

	// ==============================
	// Outputs
	// ==============================

	assign rd_addr = addr;

	assign access.write = act_pending & ~frame_is_read;
	assign access.addr  = addr;
	assign access.wdata = wdata;

	// Idle value is the frame count, picked up by the transceiver on CS_N fall.
	assign tx.load = act_pending & frame_is_read;
	assign tx.data = tx.load ? rd_data : frame_count;

	// A strobe only follows a data byte of a write frame.
	write_only_in_write_frame: assert property (
		@(posedge clk) disable iff (reset)
		access.write |-> $past(rx.valid && !expect_cmd && !frame_is_read)
	);

endmodule

`default_nettype wire

/* design/reg_bank.sv */
`timescale 1ns/10ps
`default_nettype none
`include "spi_reg_config.svh"

module reg_bank (
	input wire clk,
	input wire reset,
	input wire reg_pkg::reg_access_t access,
	input wire [`REG_ADDR_W-1:0] rd_addr,
	output logic [7:0] rd_data,
	input wire [7:0] gpio_in,
	output logic [7:0] gpio_out
);

	// ==============================
	// Storage
	// ==============================

	localparam logic [`REG_ADDR_W-1:0] in_reg_addr = `REG_ADDR_W'(`GPIO_IN_ADDR);

	logic [7:0] regs [`REG_COUNT];          // Register file.
	logic       wr_en;                      // Strobe minus read-only slot.

	assign wr_en = access.write && (access.addr != in_reg_addr);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= 8'h00;           // Bank comes up all zero.
		end else if (wr_en) begin
			regs[access.addr] <= access.wdata;
		end
	end

	// ==============================
	// Read and pin mapping
	// ==============================

	// Input register is live pins, not storage.
	assign rd_data = (rd_addr == in_reg_addr) ? gpio_in : regs[rd_addr];

	assign gpio_out = regs[0];              // Register 0 drives the pins.

	// An unknown index would corrupt an arbitrary entry.
	write_addr_known: assert property (
		@(posedge clk) disable iff (reset)
		access.write |-> !$isunknown(access.addr)
	);

endmodule

`default_nettype wire

/* design/spi_reg_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "spi_reg_config.svh"

module spi_reg_top (
	input wire clk,
	input wire reset,
	input wire spi_sck,
	input wire spi_mosi,
	input wire spi_cs_n,
	output logic spi_miso,
	input wire [7:0] gpio_in,
	output logic [7:0] gpio_out
);

	// ==============================
	// Stage links
	// ==============================

	spi_pkg::spi_events_t   events;     // Sync to transceiver and decoder.
	spi_pkg::rx_byte_t      rx;         // Received bytes.
	spi_pkg::tx_byte_t      tx;         // Bytes to send.
	reg_pkg::reg_access_t   access;     // Decoder write port.
	logic [`REG_ADDR_W-1:0] rd_addr;    // Decoder read pointer.
	logic [7:0]             rd_data;    // Combinational read data.

	spi_input_sync u_sync (
		.clk      (clk),
		.reset    (reset),
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi),
		.spi_cs_n (spi_cs_n),
		.events   (events)
	);

	spi_device_transceiver u_xcvr (
		.clk      (clk),
		.reset    (reset),
		.events   (events),
		.tx       (tx),
		.rx       (rx),
		.spi_miso (spi_miso)
	);

	spi_frame_decoder u_decoder (
		.clk      (clk),
		.reset    (reset),
		.events   (events),
		.rx       (rx),
		.tx       (tx),
		.access   (access),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	reg_bank u_regs (
		.clk      (clk),
		.reset    (reset),
		.access   (access),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out)
	);

endmodule

`default_nettype wire

/* test/tb_spi_reg_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_spi_reg_top;

	// ==============================
	// Test vectors
	// ==============================

	localparam int name_bytes = 32;                         // Longest test name.
	localparam int max_bytes  = 16;                         // Longest frame.
	localparam data_file      = "test/spi_testdata.txt";
	localparam logic [8*name_bytes-1:0] comment_mark = "#"; // Starts a comment line.

	typedef struct packed {
		logic [8*name_bytes-1:0] name;                      // Right-aligned ASCII.
		logic [7:0]              gpio_in;                   // Pins during the frame.
		logic [4:0]              count;                     // Bytes in the frame.
		logic [8*max_bytes-1:0]  mosi;                      // Byte b at [8*b +: 8].
		logic [8*max_bytes-1:0]  miso;                      // Expected replies.
		logic [7:0]              gpio_out;                  // Expected after CS_N rises.
	} test_vec_t;

	test_vec_t tests[$];                                    // One entry per frame.
	bit load_ok        = 1'b1;
	int limit_cycles   = 0;                                 // Watchdog budget.
	int mismatch_count = 0;
	int failed_tests   = 0;

	// ==============================
	// DUT
	// ==============================

	logic       clk = 1'b0;
	logic       reset;
	logic       spi_sck;
	logic       spi_mosi;
	logic       spi_cs_n;
	logic       spi_miso;
	logic [7:0] gpio_in;
	logic [7:0] gpio_out;

	always #2 clk = ~clk;                                   // 4 ns period.

	spi_reg_top u_dut (
		.clk      (clk),
		.reset    (reset),
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi),
		.spi_cs_n (spi_cs_n),
		.spi_miso (spi_miso),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out)
	);

	function automatic string name_of(input logic [8*name_bytes-1:0] raw);
		return string'(raw);                                // Drops the leading nulls.
	endfunction

	task automatic check_value(input string test_name, input string what,
			input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected %02h, actual %02h",
				test_name, what, expected, actual);
			mismatch_count++;
		end
	endtask

	// Reads one record per test, skipping lines that open with #.
	task automatic load_tests();
		int fd;
		int code;
		int value;
		int count;
		int fields;
		int b;
		bit done;
		logic [8*name_bytes-1:0] token;
		logic [8*128-1:0] rest;
		test_vec_t t;
		fd = $fopen(data_file, "r");
		if (fd == 0) begin
			$display("could not open the test data file %s", data_file);
			load_ok = 1'b0;
			return;
		end
		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, "%s", token);
			if (code != 1) begin
				done = 1'b1;                                // End of file.
			end else if (token == comment_mark) begin
				code = $fgets(rest, fd);                    // Rest of the comment.
			end else begin
				t = '0;
				t.name = token;
				fields = $fscanf(fd, "%h", value);
				t.gpio_in = value[7:0];
				fields += $fscanf(fd, "%d", count);
				if (count > max_bytes) begin
					$display("test %s has %0d bytes, more than %0d", name_of(token), count,
						max_bytes);
					load_ok = 1'b0;
					done = 1'b1;
				end else begin
					t.count = count[4:0];
					for (b = 0; b < count; b++) begin
						fields += $fscanf(fd, "%h", value);
						t.mosi[b*8 +: 8] = value[7:0];
					end
					for (b = 0; b < count; b++) begin
						fields += $fscanf(fd, "%h", value);
						t.miso[b*8 +: 8] = value[7:0];
					end
					fields += $fscanf(fd, "%h", value);
					t.gpio_out = value[7:0];
					if (fields != 3 + 2 * count) begin
						$display("test %s in %s is incomplete", name_of(token), data_file);
						load_ok = 1'b0;
						done = 1'b1;
					end else begin
						tests.push_back(t);
					end
				end
			end
		end
		$fclose(fd);
	endtask

	// ==============================
	// SPI host model
	// ==============================

	// Mode 0 host. MOSI changes with SCK fall and MISO is sampled just before each rise.
	task automatic run_frame(input test_vec_t t, output logic [8*max_bytes-1:0] seen);
		int half;
		int b;
		int k;
		logic [7:0] rx_byte;
		half = 4 + ($urandom % 3);                          // 4 to 6 clk per SCK phase.
		seen = '0;
		@(posedge clk);
		spi_cs_n <= 1'b0;
		repeat (8) @(posedge clk);                          // Frame count reaches MISO.
		for (b = 0; b < t.count; b++) begin
			for (k = 7; k >= 0; k--) begin
				spi_mosi <= t.mosi[b*8 + k];                // MSB first.
				repeat (half - 1) @(posedge clk);
				@(negedge clk);
				rx_byte[k] = spi_miso;                      // Stable between edges.
				@(posedge clk);
				spi_sck <= 1'b1;
				repeat (half) @(posedge clk);
				spi_sck <= 1'b0;
			end
			seen[b*8 +: 8] = rx_byte;
		end
		repeat (half) @(posedge clk);
		spi_cs_n <= 1'b1;                                   // Frame ends.
		spi_mosi <= 1'b0;
		repeat (8) @(posedge clk);
	endtask

	// ==============================
	// Stimulus and report
	// ==============================

	initial begin
		int i;
		int b;
		int errors_before;
		string name;
		test_vec_t t;
		logic [8*max_bytes-1:0] seen;
		void'($urandom(32'h3ca3));                          // One seed for the run.
		reset    <= 1'b1;
		spi_sck  <= 1'b0;
		spi_mosi <= 1'b0;
		spi_cs_n <= 1'b1;                                   // Device deselected.
		gpio_in  <= 8'h00;
		load_tests();
		limit_cycles = tests.size() * 16 * 8 * 16;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		for (i = 0; i < tests.size(); i++) begin
			t = tests[i];
			name = name_of(t.name);
			errors_before = mismatch_count;
			@(posedge clk);
			gpio_in <= t.gpio_in;
			run_frame(t, seen);
			for (b = 0; b < t.count; b++)
				check_value(name, $sformatf("miso byte %0d", b), t.miso[b*8 +: 8],
					seen[b*8 +: 8]);
			@(negedge clk);
			check_value(name, "gpio_out", t.gpio_out, gpio_out);
			if (mismatch_count == errors_before) begin
				$display("done %s: ok", name);
			end else begin
				failed_tests++;
				$display("done %s: %0d mismatches", name, mismatch_count - errors_before);
			end
		end
		$display("tests run %0d, tests failed %0d, mismatches %0d",
			tests.size(), failed_tests, mismatch_count);
		if (load_ok && tests.size() > 0 && mismatch_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Budget scales with the number of frames read.
	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: the frames did not finish within %0d clock cycles", limit_cycles);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
design/spi_pkg.sv
design/reg_pkg.sv
design/spi_input_sync.sv
design/spi_device_transceiver.sv
design/spi_frame_decoder.sv
design/reg_bank.sv
design/spi_reg_top.sv
test/tb_spi_reg_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the SPI register port testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_spi_reg_top \
	-f project.f \
	--Mdir obj_dir \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation finished, log in sim.log"
exit 0

/* test/spi_testdata.txt */
# name gpio_in nbytes mosi[nbytes] miso[nbytes] gpio_out, all hex except nbytes
# miso byte 0 is the count of earlier frames, write data slots shift out zero

reset_state        5a 1 00 00 00
write_gpio         5a 2 00 a5 01 00 a5
read_gpio_out      5a 2 80 00 02 a5 a5

write_wrap         5a 5 0e 11 22 33 44 03 00 00 00 00 33
read_wrap          5a 5 8e 00 00 00 00 04 11 22 33 5a 33

read_gpio_in       c3 2 81 00 05 c3 33
write_gpio_in      c3 2 01 77 06 00 33
read_gpio_in_new   3c 3 81 00 00 07 3c 00 33

write_block        3c 5 02 de ad be ef 08 00 00 00 00 33
read_block         3c 5 82 00 00 00 00 09 de ad be ef 33
read_addr_mod      3c 3 93 00 00 0a ad be 33
write_addr_mod     3c 2 70 0f 0b 00 0f
read_mixed         3c 4 80 00 00 00 0c 0f 3c de 0f

count_only         3c 1 80 0d 0f
empty_frame        3c 0 0f
count_after_empty  3c 2 8f 00 0f 22 0f
